// File: filelist.f
+incdir+logic
logic/control_pkg.sv
logic/register_map.sv
logic/micro_sequencer.sv
logic/control_unit.sv
testbench/tb_control_unit.sv

// File: logic/control_config.svh
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

`define OPCODE_W     4
`define REG_FIELD_W  4
`define ADDR_W       8
`define FLAG_W       4
`define ALU_W        4
`define FUN_W        2
`define SEL_W        4
`define RF_OUT_W     3
`define ARF_OUT_W    2
`define MUX_W        2
`define STEP_W       2

`define OP_AND   4'd0
`define OP_OR    4'd1
`define OP_NOT   4'd2
`define OP_ADD   4'd3
`define OP_SUB   4'd4
`define OP_LSR   4'd5
`define OP_LSL   4'd6
`define OP_BRA   4'd9
`define OP_BNE   4'd10
`define OP_MOV   4'd11
`define OP_LD    4'd12
`define OP_ST    4'd13
`define OP_PULL  4'd14
`define OP_PUSH  4'd15

`define ALU_PASS_A  4'b0000
`define ALU_PASS_B  4'b0001
`define ALU_NOT     4'b0010
`define ALU_ADD     4'b0100
`define ALU_SUB     4'b0101
`define ALU_AND     4'b0111
`define ALU_OR      4'b1000
`define ALU_LSL     4'b1011
`define ALU_LSR     4'b1100

`define FUN_LOAD  2'b01
`define FUN_DEC   2'b10
`define FUN_INC   2'b11

`define ARF_AR  2'b00
`define ARF_SP  2'b01
`define ARF_PC  2'b11

`define RF_R1       4'b1000
`define RF_R2       4'b0100
`define RF_R3       4'b0010
`define RF_R4       4'b0001
`define ARF_SEL_SP  4'b0010
`define ARF_SEL_AR  4'b0100
`define ARF_SEL_PC  4'b1000

`define RF_OUT_R1  3'b100
`define RF_OUT_R2  3'b101
`define RF_OUT_R3  3'b110
`define RF_OUT_R4  3'b111

`define MUX_ALU   2'b00
`define MUX_MEM   2'b01
`define MUX_IR    2'b10
`define MUXC_RF   1'b0
`define MUXC_ARF  1'b1

`define STEP_T0  2'd0
`define STEP_T1  2'd1
`define STEP_T2  2'd2
`define STEP_T3  2'd3

`define ZERO_FLAG_BIT  0

`endif

// File: logic/control_pkg.sv
`include "control_config.svh"

package control_pkg;

    // Register operations
    typedef struct packed {
        logic [`OPCODE_W-1:0]    opcode;
        logic [`REG_FIELD_W-1:0] dst;
        logic [`REG_FIELD_W-1:0] src1;
        logic [`REG_FIELD_W-1:0] src2;
    } reg_form_t;

    // LD, ST, branches, stack ops
    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic                 spare;
        logic                 direct;  // 1 selects memory operand
        logic [1:0]           rsel;
        logic [`ADDR_W-1:0]   addr;
    } addr_form_t;

    typedef union packed {
        reg_form_t  r;
        addr_form_t a;
    } instr_word_t;

endpackage

// File: logic/control_unit.sv
`timescale 1ns/1ps
`include "control_config.svh"

module control_unit
    import control_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  instr_word_t           ir_word,
    input  logic [`FLAG_W-1:0]    alu_flags,
    output logic [`RF_OUT_W-1:0]  rf_out_a_sel,
    output logic [`RF_OUT_W-1:0]  rf_out_b_sel,
    output logic [`FUN_W-1:0]     rf_fun_sel,
    output logic [`SEL_W-1:0]     rf_reg_sel,
    output logic [`ALU_W-1:0]     alu_fun_sel,
    output logic [`ARF_OUT_W-1:0] arf_out_c_sel,
    output logic [`ARF_OUT_W-1:0] arf_out_d_sel,
    output logic [`FUN_W-1:0]     arf_fun_sel,
    output logic [`SEL_W-1:0]     arf_reg_sel,
    output logic                  ir_lh,
    output logic                  ir_enable,
    output logic                  mem_wr,
    output logic [`MUX_W-1:0]     mux_a_sel,
    output logic [`MUX_W-1:0]     mux_b_sel,
    output logic                  mux_c_sel
);

    logic                  src_a_is_arf;
    logic [`RF_OUT_W-1:0]  src_a_rf_sel;
    logic [`ARF_OUT_W-1:0] src_a_arf_sel;
    logic [`RF_OUT_W-1:0]  src_b_rf_sel;
    logic                  dst_is_arf;
    logic [`SEL_W-1:0]     dst_rf_onehot;
    logic [`SEL_W-1:0]     dst_arf_onehot;
    logic [`SEL_W-1:0]     rsel_rf_onehot;
    logic [`RF_OUT_W-1:0]  rsel_rf_out_sel;

    register_map i_register_map (
        .ir_word         (ir_word),
        .src_a_is_arf    (src_a_is_arf),
        .src_a_rf_sel    (src_a_rf_sel),
        .src_a_arf_sel   (src_a_arf_sel),
        .src_b_rf_sel    (src_b_rf_sel),
        .dst_is_arf      (dst_is_arf),
        .dst_rf_onehot   (dst_rf_onehot),
        .dst_arf_onehot  (dst_arf_onehot),
        .rsel_rf_onehot  (rsel_rf_onehot),
        .rsel_rf_out_sel (rsel_rf_out_sel)
    );

    micro_sequencer i_micro_sequencer (
        .clock           (clock),
        .rst_n           (rst_n),
        .ir_word         (ir_word),
        .zero_flag       (alu_flags[`ZERO_FLAG_BIT]),  // Only Z is used
        .src_a_is_arf    (src_a_is_arf),
        .src_a_rf_sel    (src_a_rf_sel),
        .src_a_arf_sel   (src_a_arf_sel),
        .src_b_rf_sel    (src_b_rf_sel),
        .dst_is_arf      (dst_is_arf),
        .dst_rf_onehot   (dst_rf_onehot),
        .dst_arf_onehot  (dst_arf_onehot),
        .rsel_rf_onehot  (rsel_rf_onehot),
        .rsel_rf_out_sel (rsel_rf_out_sel),
        .rf_out_a_sel    (rf_out_a_sel),
        .rf_out_b_sel    (rf_out_b_sel),
        .rf_fun_sel      (rf_fun_sel),
        .rf_reg_sel      (rf_reg_sel),
        .alu_fun_sel     (alu_fun_sel),
        .arf_out_c_sel   (arf_out_c_sel),
        .arf_out_d_sel   (arf_out_d_sel),
        .arf_fun_sel     (arf_fun_sel),
        .arf_reg_sel     (arf_reg_sel),
        .ir_lh           (ir_lh),
        .ir_enable       (ir_enable),
        .mem_wr          (mem_wr),
        .mux_a_sel       (mux_a_sel),
        .mux_b_sel       (mux_b_sel),
        .mux_c_sel       (mux_c_sel)
    );

endmodule

// File: logic/micro_sequencer.sv
`timescale 1ns/1ps
`include "control_config.svh"

module micro_sequencer
    import control_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  instr_word_t           ir_word,
    input  logic                  zero_flag,
    input  logic                  src_a_is_arf,
    input  logic [`RF_OUT_W-1:0]  src_a_rf_sel,
    input  logic [`ARF_OUT_W-1:0] src_a_arf_sel,
    input  logic [`RF_OUT_W-1:0]  src_b_rf_sel,
    input  logic                  dst_is_arf,
    input  logic [`SEL_W-1:0]     dst_rf_onehot,
    input  logic [`SEL_W-1:0]     dst_arf_onehot,
    input  logic [`SEL_W-1:0]     rsel_rf_onehot,
    input  logic [`RF_OUT_W-1:0]  rsel_rf_out_sel,
    output logic [`RF_OUT_W-1:0]  rf_out_a_sel,
    output logic [`RF_OUT_W-1:0]  rf_out_b_sel,
    output logic [`FUN_W-1:0]     rf_fun_sel,
    output logic [`SEL_W-1:0]     rf_reg_sel,
    output logic [`ALU_W-1:0]     alu_fun_sel,
    output logic [`ARF_OUT_W-1:0] arf_out_c_sel,
    output logic [`ARF_OUT_W-1:0] arf_out_d_sel,
    output logic [`FUN_W-1:0]     arf_fun_sel,
    output logic [`SEL_W-1:0]     arf_reg_sel,
    output logic                  ir_lh,
    output logic                  ir_enable,
    output logic                  mem_wr,
    output logic [`MUX_W-1:0]     mux_a_sel,
    output logic [`MUX_W-1:0]     mux_b_sel,
    output logic                  mux_c_sel
);

    logic [`STEP_W-1:0]   step;
    logic [`STEP_W-1:0]   last_step;
    logic [`OPCODE_W-1:0] opcode;
    logic [`ALU_W-1:0]    op_alu;
    logic [`MUX_W-1:0]    value_src;
    logic                 is_binary;

    assign opcode    = ir_word.r.opcode;
    assign value_src = ir_word.a.direct ? `MUX_MEM : `MUX_IR;
    assign is_binary = opcode inside {`OP_AND, `OP_OR, `OP_ADD, `OP_SUB};

    always_comb begin
        case (opcode)
            `OP_LD, `OP_ST, `OP_BRA, `OP_PUSH, `OP_PULL: last_step = `STEP_T3;
            `OP_BNE: last_step = zero_flag ? `STEP_T2 : `STEP_T3;  // Not taken ends early
            default: last_step = `STEP_T2;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            step <= `STEP_T0;
        end else if (step == last_step) begin
            step <= `STEP_T0;
        end else begin
            step <= step + 2'd1;
        end
    end

    always_comb begin
        case (opcode)
            `OP_AND: op_alu = `ALU_AND;
            `OP_OR:  op_alu = `ALU_OR;
            `OP_NOT: op_alu = `ALU_NOT;
            `OP_ADD: op_alu = `ALU_ADD;
            `OP_SUB: op_alu = `ALU_SUB;
            `OP_LSR: op_alu = `ALU_LSR;
            `OP_LSL: op_alu = `ALU_LSL;
            default: op_alu = `ALU_PASS_A;  // MOV
        endcase
    end

    always_comb begin
        rf_out_a_sel  = '0;
        rf_out_b_sel  = '0;
        rf_fun_sel    = '0;
        rf_reg_sel    = '0;
        alu_fun_sel   = '0;
        arf_out_c_sel = '0;
        arf_out_d_sel = '0;
        arf_fun_sel   = '0;
        arf_reg_sel   = '0;
        ir_lh         = 1'b0;
        ir_enable     = 1'b0;
        mem_wr        = 1'b0;
        mux_a_sel     = '0;
        mux_b_sel     = '0;
        mux_c_sel     = 1'b0;
        if (rst_n) begin
            if (step == `STEP_T0 || step == `STEP_T1) begin
                arf_out_d_sel = `ARF_PC;  // Fetch byte at PC
                ir_enable     = 1'b1;
                ir_lh         = (step == `STEP_T1);
                arf_reg_sel   = `ARF_SEL_PC;
                arf_fun_sel   = `FUN_INC;
            end else begin
                case (opcode)
                    `OP_AND, `OP_OR, `OP_NOT, `OP_ADD, `OP_SUB, `OP_LSR, `OP_LSL,
                    `OP_MOV: begin
                        alu_fun_sel = op_alu;
                        if (src_a_is_arf) begin
                            mux_c_sel     = `MUXC_ARF;
                            arf_out_c_sel = src_a_arf_sel;
                        end else begin
                            mux_c_sel    = `MUXC_RF;
                            rf_out_a_sel = src_a_rf_sel;
                        end
                        if (is_binary) begin
                            rf_out_b_sel = src_b_rf_sel;
                        end
                        if (dst_is_arf) begin
                            mux_b_sel   = `MUX_ALU;
                            arf_fun_sel = `FUN_LOAD;
                            arf_reg_sel = dst_arf_onehot;
                        end else begin
                            mux_a_sel  = `MUX_ALU;
                            rf_fun_sel = `FUN_LOAD;
                            rf_reg_sel = dst_rf_onehot;
                        end
                    end
                    `OP_LD, `OP_BRA, `OP_BNE, `OP_ST: begin
                        if (step == `STEP_T2) begin
                            // AR takes the address byte for the memory access
                            if ((ir_word.a.direct || opcode == `OP_ST) &&
                                !(opcode == `OP_BNE && zero_flag)) begin
                                mux_b_sel   = `MUX_IR;
                                arf_fun_sel = `FUN_LOAD;
                                arf_reg_sel = `ARF_SEL_AR;
                            end
                        end else if (opcode == `OP_ST) begin
                            arf_out_d_sel = `ARF_AR;
                            rf_out_b_sel  = rsel_rf_out_sel;
                            alu_fun_sel   = `ALU_PASS_B;
                            mem_wr        = 1'b1;
                        end else begin
                            if (ir_word.a.direct) begin
                                arf_out_d_sel = `ARF_AR;
                            end
                            if (opcode == `OP_LD) begin
                                mux_a_sel  = value_src;
                                rf_fun_sel = `FUN_LOAD;
                                rf_reg_sel = rsel_rf_onehot;
                            end else begin
                                mux_b_sel   = value_src;  // New PC
                                arf_fun_sel = `FUN_LOAD;
                                arf_reg_sel = `ARF_SEL_PC;
                            end
                        end
                    end
                    `OP_PUSH: begin
                        if (step == `STEP_T2) begin
                            arf_out_d_sel = `ARF_SP;
                            rf_out_b_sel  = rsel_rf_out_sel;
                            alu_fun_sel   = `ALU_PASS_B;
                            mem_wr        = 1'b1;
                        end else begin
                            arf_reg_sel = `ARF_SEL_SP;
                            arf_fun_sel = `FUN_DEC;
                        end
                    end
                    `OP_PULL: begin
                        if (step == `STEP_T2) begin
                            arf_reg_sel = `ARF_SEL_SP;
                            arf_fun_sel = `FUN_INC;
                        end else begin
                            arf_out_d_sel = `ARF_SP;
                            mux_a_sel     = `MUX_MEM;
                            rf_fun_sel    = `FUN_LOAD;
                            rf_reg_sel    = rsel_rf_onehot;
                        end
                    end
                    default: ;  // Opcodes 7 and 8 idle at T2
                endcase
            end
        end
    end

    a_reg_sel_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(rf_reg_sel) && $onehot0(arf_reg_sel))
        else $error("register select not one-hot");

    a_no_write_in_fetch: assert property (@(posedge clock) disable iff (!rst_n)
        !(mem_wr && ir_enable))
        else $error("memory write during fetch");

    a_wrap_after_t3: assert property (@(posedge clock) disable iff (!rst_n)
        step == `STEP_T3 |=> step == `STEP_T0)
        else $error("step counter did not wrap after T3");

endmodule

// File: logic/register_map.sv
`timescale 1ns/1ps
`include "control_config.svh"

module register_map
    import control_pkg::*;
(
    input  instr_word_t                ir_word,
    output logic                       src_a_is_arf,
    output logic [`RF_OUT_W-1:0]       src_a_rf_sel,
    output logic [`ARF_OUT_W-1:0]      src_a_arf_sel,
    output logic [`RF_OUT_W-1:0]       src_b_rf_sel,
    output logic                       dst_is_arf,
    output logic [`SEL_W-1:0]          dst_rf_onehot,
    output logic [`SEL_W-1:0]          dst_arf_onehot,
    output logic [`SEL_W-1:0]          rsel_rf_onehot,
    output logic [`RF_OUT_W-1:0]       rsel_rf_out_sel
);

    function automatic logic [`RF_OUT_W-1:0] rf_out_code(input logic [1:0] num);
        case (num)
            2'd0:    return `RF_OUT_R1;
            2'd1:    return `RF_OUT_R2;
            2'd2:    return `RF_OUT_R3;
            default: return `RF_OUT_R4;
        endcase
    endfunction

    function automatic logic [`SEL_W-1:0] rf_onehot(input logic [1:0] num);
        case (num)
            2'd0:    return `RF_R1;
            2'd1:    return `RF_R2;
            2'd2:    return `RF_R3;
            default: return `RF_R4;
        endcase
    endfunction

    // Numbers 4..7 after the top bit is stripped
    function automatic logic [`ARF_OUT_W-1:0] arf_out_code(input logic [1:0] num);
        case (num)
            2'd0:    return `ARF_SP;
            2'd1:    return `ARF_AR;
            default: return `ARF_PC;  // 6 and 7 both PC
        endcase
    endfunction

    function automatic logic [`SEL_W-1:0] arf_onehot(input logic [1:0] num);
        case (num)
            2'd0:    return `ARF_SEL_SP;
            2'd1:    return `ARF_SEL_AR;
            default: return `ARF_SEL_PC;
        endcase
    endfunction

    assign src_a_is_arf    = ir_word.r.src1[2];
    assign src_a_rf_sel    = rf_out_code(ir_word.r.src1[1:0]);
    assign src_a_arf_sel   = arf_out_code(ir_word.r.src1[1:0]);
    assign src_b_rf_sel    = rf_out_code(ir_word.r.src2[1:0]);  // Always a general register
    assign dst_is_arf      = ir_word.r.dst[2];
    assign dst_rf_onehot   = rf_onehot(ir_word.r.dst[1:0]);
    assign dst_arf_onehot  = arf_onehot(ir_word.r.dst[1:0]);
    assign rsel_rf_onehot  = rf_onehot(ir_word.a.rsel);
    assign rsel_rf_out_sel = rf_out_code(ir_word.a.rsel);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_control_unit \
    --Mdir obj_dir -o sim_control_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_control_unit > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

exit 0

// File: testbench/control_stimulus.txt
# ir z | rf_a rf_b rf_fun rf_reg alu arf_c arf_d arf_fun arf_reg lh en wr mux_a mux_b mux_c
# one line per cycle after reset, all values in hex
3201 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
3201 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
3201 0 4 5 1 2 4 0 0 0 0 0 0 0 0 0 0
4543 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
4543 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
4543 0 0 7 0 0 5 1 0 1 4 0 0 0 0 0 1
2013 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
2013 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
2013 0 5 0 1 8 2 0 0 0 0 0 0 0 0 0 0
6360 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
6360 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
6360 0 0 0 1 1 b 3 0 0 0 0 0 0 0 0 1
b600 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
b600 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
b600 0 4 0 0 0 0 0 0 1 8 0 0 0 0 0 0
c540 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
c540 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
c540 0 0 0 0 0 0 0 0 1 4 0 0 0 0 2 0
c540 0 0 0 1 4 0 0 0 0 0 0 0 0 1 0 0
c37f 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
c37f 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
c37f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
c37f 0 0 0 1 1 0 0 0 0 0 0 0 0 2 0 0
d420 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
d420 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
d420 0 0 0 0 0 0 0 0 1 4 0 0 0 0 2 0
d420 0 0 4 0 0 1 0 0 0 0 0 0 1 0 0 0
9005 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
9005 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
9005 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
9005 0 0 0 0 0 0 0 0 1 8 0 0 0 0 2 0
a433 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
a433 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
a433 0 0 0 0 0 0 0 0 1 4 0 0 0 0 2 0
a433 0 0 0 0 0 0 0 0 1 8 0 0 0 0 1 0
a433 1 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
a433 1 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
a433 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
f100 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
f100 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
f100 0 0 5 0 0 1 0 1 0 0 0 0 1 0 0 0
f100 0 0 0 0 0 0 0 0 2 2 0 0 0 0 0 0
e200 0 0 0 0 0 0 0 3 3 8 0 1 0 0 0 0
e200 0 0 0 0 0 0 0 3 3 8 1 1 0 0 0 0
e200 0 0 0 0 0 0 0 0 3 2 0 0 0 0 0 0
e200 0 0 0 1 2 0 0 1 0 0 0 0 0 1 0 0

// File: testbench/tb_control_unit.sv
`timescale 1ns/1ps
`include "control_config.svh"

module tb_control_unit
    import control_pkg::*;
;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = 200;
    localparam int EXP_LINES    = 46;
    localparam int NUM_OUTS     = 15;

    logic                  clock;
    logic                  rst_n;
    instr_word_t           ir_word;
    logic [`FLAG_W-1:0]    alu_flags;
    logic [`RF_OUT_W-1:0]  rf_out_a_sel;
    logic [`RF_OUT_W-1:0]  rf_out_b_sel;
    logic [`FUN_W-1:0]     rf_fun_sel;
    logic [`SEL_W-1:0]     rf_reg_sel;
    logic [`ALU_W-1:0]     alu_fun_sel;
    logic [`ARF_OUT_W-1:0] arf_out_c_sel;
    logic [`ARF_OUT_W-1:0] arf_out_d_sel;
    logic [`FUN_W-1:0]     arf_fun_sel;
    logic [`SEL_W-1:0]     arf_reg_sel;
    logic                  ir_lh;
    logic                  ir_enable;
    logic                  mem_wr;
    logic [`MUX_W-1:0]     mux_a_sel;
    logic [`MUX_W-1:0]     mux_b_sel;
    logic                  mux_c_sel;

    logic [15:0] exp_val [NUM_OUTS];
    string       out_names [NUM_OUTS] = '{
        "rf_out_a_sel", "rf_out_b_sel", "rf_fun_sel", "rf_reg_sel", "alu_fun_sel",
        "arf_out_c_sel", "arf_out_d_sel", "arf_fun_sel", "arf_reg_sel", "ir_lh",
        "ir_enable", "mem_wr", "mux_a_sel", "mux_b_sel", "mux_c_sel"
    };

    control_unit i_control_unit (
        .clock         (clock),
        .rst_n         (rst_n),
        .ir_word       (ir_word),
        .alu_flags     (alu_flags),
        .rf_out_a_sel  (rf_out_a_sel),
        .rf_out_b_sel  (rf_out_b_sel),
        .rf_fun_sel    (rf_fun_sel),
        .rf_reg_sel    (rf_reg_sel),
        .alu_fun_sel   (alu_fun_sel),
        .arf_out_c_sel (arf_out_c_sel),
        .arf_out_d_sel (arf_out_d_sel),
        .arf_fun_sel   (arf_fun_sel),
        .arf_reg_sel   (arf_reg_sel),
        .ir_lh         (ir_lh),
        .ir_enable     (ir_enable),
        .mem_wr        (mem_wr),
        .mux_a_sel     (mux_a_sel),
        .mux_b_sel     (mux_b_sel),
        .mux_c_sel     (mux_c_sel)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs();
        logic [15:0] act [NUM_OUTS];
        act = '{16'(rf_out_a_sel), 16'(rf_out_b_sel), 16'(rf_fun_sel), 16'(rf_reg_sel),
                16'(alu_fun_sel), 16'(arf_out_c_sel), 16'(arf_out_d_sel), 16'(arf_fun_sel),
                16'(arf_reg_sel), 16'(ir_lh), 16'(ir_enable), 16'(mem_wr),
                16'(mux_a_sel), 16'(mux_b_sel), 16'(mux_c_sel)};
        for (int i = 0; i < NUM_OUTS; i++) begin
            check_value(out_names[i], exp_val[i], act[i]);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    initial begin
        int          fd;
        int          cycles;
        int          lines;
        int          fields;
        string       line;
        logic [15:0] word;
        logic [15:0] zf;

        rst_n       = 1'b0;
        ir_word     = 16'h3201;  // Decodable word, must be ignored in reset
        alu_flags   = '0;
        for (int i = 0; i < NUM_OUTS; i++) begin
            exp_val[i] = '0;
        end

        cycles = 0;
        while (cycles < RESET_CYCLES) begin
            @(posedge clock);
            #8;
            compare_outputs();
            cycles++;
            if (cycles > MAX_CYCLES) begin
                fail_run("Reset phase did not finish in time");
            end
        end

        fd = $fopen("testbench/control_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file");
        end

        lines  = 0;
        cycles = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             word, zf, exp_val[0], exp_val[1], exp_val[2], exp_val[3],
                             exp_val[4], exp_val[5], exp_val[6], exp_val[7], exp_val[8],
                             exp_val[9], exp_val[10], exp_val[11], exp_val[12],
                             exp_val[13], exp_val[14]);
            if (fields != 17) begin
                fail_run($sformatf("Stimulus line %0d is malformed", lines + 1));
            end
            @(posedge clock);
            #1;
            rst_n                       = 1'b1;
            ir_word                     = word;
            alu_flags                   = '0;
            alu_flags[`ZERO_FLAG_BIT]   = zf[0];
            #7;
            compare_outputs();  // Just before the next edge
            lines++;
            cycles++;
            if (cycles > MAX_CYCLES) begin
                fail_run("Stimulus file did not end within the cycle limit");
            end
        end
        $fclose(fd);

        if (lines != EXP_LINES) begin
            fail_run($sformatf("Stimulus file held %0d lines where %0d were expected",
                               lines, EXP_LINES));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule
